// File: hdl/ap_read_buf.sv
`timescale 1ns/1ns
`default_nettype none

module ap_read_buf import dap_pkg::*; (
    input  wire           tck,
    input  wire           trstn,
    input  wire           push,
    input  wire buf_out_t push_data,
    input  wire           dpop,
    input  wire           rpop,
    input  wire           rrstn,
    output buf_out_t      head
);

    word_t             dq [buf_depth];
    word_t             rq [buf_depth];
    logic [buf_aw:0]   wptr;
    logic [buf_aw:0]   dptr;
    logic [buf_aw:0]   rptr;
    logic              d_empty;
    logic              r_empty;
    logic              full;

    assign d_empty = wptr == dptr;
    assign r_empty = wptr == rptr;
    // Full once either read pointer lags a whole lap.
    assign full    = {~wptr[buf_aw], wptr[buf_aw-1:0]} == dptr ||
                     {~wptr[buf_aw], wptr[buf_aw-1:0]} == rptr;

    assign head.rdata = d_empty ? '0 : dq[dptr[buf_aw-1:0]];
    assign head.rresp = r_empty ? '0 : rq[rptr[buf_aw-1:0]];

    always_ff @(posedge tck) begin
        if (push && !full) begin
            dq[wptr[buf_aw-1:0]] <= push_data.rdata;
            rq[wptr[buf_aw-1:0]] <= push_data.rresp;
        end
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            wptr <= '0;
            dptr <= '0;
            rptr <= '0;
        end else if (!rrstn) begin
            wptr <= '0;
            dptr <= '0;
            rptr <= '0;
        end else begin
            if (push && !full) begin
                wptr <= wptr + 1'b1;
            end
            if (dpop && !d_empty) begin
                dptr <= dptr + 1'b1;
            end
            if (rpop && !r_empty) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dap_pkg.sv
`default_nettype none

package dap_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  ir_t;
    typedef logic [7:2]  ap_addr_t;
    typedef logic [7:0]  ap_sel_t;
    typedef logic [5:0]  mem_addr_t;

    localparam ir_t ir_abort  = 4'h8;
    localparam ir_t ir_dpacc  = 4'ha;
    localparam ir_t ir_apacc  = 4'hb;
    localparam ir_t ir_apdbuf = 4'hc;
    localparam ir_t ir_aprbuf = 4'hd;
    localparam ir_t ir_idcode = 4'he;
    localparam ir_t ir_bypass = 4'hf;

    localparam logic [2:0] ack_ok_fault = 3'h2;
    localparam logic [2:0] ack_wait     = 3'h1;

    localparam word_t       unpredictable_word = 32'hdead_dead;
    localparam logic [3:0]  dap_ver            = 4'h1;
    localparam logic [15:0] dap_partnum        = 16'h0ba1;
    localparam logic [10:0] dap_manid          = 11'h23b;

    localparam ap_addr_t ap_csw = 6'h0;
    localparam ap_addr_t ap_tar = 6'h1;
    localparam ap_addr_t ap_drw = 6'h3;

    localparam int buf_depth = 8;
    localparam int buf_aw    = $clog2(buf_depth);
    localparam int mem_words = 64;

    typedef struct packed {
        ap_sel_t  sel;
        ap_addr_t addr;
        word_t    wdata;
        logic     rnw;
    } ap_req_t;

    typedef struct packed {
        word_t rdata;
        logic  slverr;
    } ap_rsp_t;

    typedef struct packed {
        word_t rdata;
        word_t rresp;
    } buf_out_t;

    typedef struct packed {
        word_t addr;   // Byte address.
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef enum logic [3:0] {
        tap_ex2_dr = 4'h0,
        tap_ex1_dr = 4'h1,
        tap_sft_dr = 4'h2,
        tap_pau_dr = 4'h3,
        tap_sel_ir = 4'h4,
        tap_upd_dr = 4'h5,
        tap_cap_dr = 4'h6,
        tap_sel_dr = 4'h7,
        tap_ex2_ir = 4'h8,
        tap_ex1_ir = 4'h9,
        tap_sft_ir = 4'ha,
        tap_pau_ir = 4'hb,
        tap_run    = 4'hc,
        tap_upd_ir = 4'hd,
        tap_cap_ir = 4'he,
        tap_reset  = 4'hf
    } tap_state_t;

    typedef enum logic [1:0] {
        ap_idle,
        ap_access,
        ap_done
    } ap_state_t;

endpackage

`default_nettype wire

// File: hdl/dap_top.sv
`timescale 1ns/1ns
`default_nettype none

module dap_top import dap_pkg::*; (
    input  wire  tck,
    input  wire  trstn,
    input  wire  tms,
    input  wire  tdi,
    output logic tdo,
    output logic dbgrstn
);

    logic     ap_upd;
    ap_req_t  ap_req;
    logic     ap_busy;
    ap_rsp_t  ap_rsp;
    logic     ap_buf_rrstn;
    logic     ap_buf_dpop;
    logic     ap_buf_rpop;
    buf_out_t ap_buf;
    logic     buf_push;
    buf_out_t buf_in;
    mem_req_t mem_req;
    logic     mem_valid;
    ap_rsp_t  mem_rsp;

    jtag_dp jtag_dp_i (
        .tck          (tck),
        .trstn        (trstn),
        .tms          (tms),
        .tdi          (tdi),
        .tdo          (tdo),
        .ap_upd       (ap_upd),
        .ap_req       (ap_req),
        .ap_busy      (ap_busy),
        .ap_rsp       (ap_rsp),
        .ap_buf_rrstn (ap_buf_rrstn),
        .ap_buf_dpop  (ap_buf_dpop),
        .ap_buf_rpop  (ap_buf_rpop),
        .ap_buf       (ap_buf),
        .dbgrstn      (dbgrstn)
    );

    mem_ap mem_ap_i (
        .tck       (tck),
        .trstn     (trstn),
        .dbgrstn   (dbgrstn),
        .ap_upd    (ap_upd),
        .ap_req    (ap_req),
        .ap_busy   (ap_busy),
        .ap_rsp    (ap_rsp),
        .buf_push  (buf_push),
        .buf_in    (buf_in),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_rsp   (mem_rsp)
    );

    ap_read_buf ap_read_buf_i (
        .tck       (tck),
        .trstn     (trstn),
        .push      (buf_push),
        .push_data (buf_in),
        .dpop      (ap_buf_dpop),
        .rpop      (ap_buf_rpop),
        .rrstn     (ap_buf_rrstn),
        .head      (ap_buf)
    );

    debug_mem debug_mem_i (
        .tck   (tck),
        .trstn (trstn),
        .valid (mem_valid),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

// File: hdl/debug_mem.sv
`timescale 1ns/1ns
`default_nettype none

module debug_mem import dap_pkg::*; (
    input  wire           tck,
    input  wire           trstn,
    input  wire           valid,
    input  wire mem_req_t req,
    output ap_rsp_t       rsp
);

    word_t     mem [mem_words];
    mem_addr_t idx;
    logic      oor;

    assign idx = req.addr[7:2];
    assign oor = req.addr >= word_t'(mem_words * 4);

    always_ff @(posedge tck) begin
        if (valid && req.we && !oor) begin
            mem[idx] <= req.wdata;
        end
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            rsp <= '0;
        end else if (valid) begin
            rsp.slverr <= oor;
            rsp.rdata  <= (oor || req.we) ? '0 : mem[idx];   // Errored reads give zero.
        end
    end

endmodule

`default_nettype wire

// File: hdl/jtag_dp.sv
`timescale 1ns/1ns
`default_nettype none

module jtag_dp import dap_pkg::*; (
    input  wire           tck,
    input  wire           trstn,
    input  wire           tms,
    input  wire           tdi,
    output logic          tdo,

    output logic          ap_upd,
    output ap_req_t       ap_req,
    input  wire           ap_busy,
    input  wire ap_rsp_t  ap_rsp,

    output logic          ap_buf_rrstn,
    output logic          ap_buf_dpop,
    output logic          ap_buf_rpop,
    input  wire buf_out_t ap_buf,

    output logic          dbgrstn
);

    typedef struct packed {
        logic        csyspwrupack;
        logic        csyspwrupreq;
        logic        cdbgpwrupack;
        logic        cdbgpwrupreq;
        logic        cdbgrstack;
        logic        cdbgrstreq;
        logic [11:0] trncnt;
        logic [3:0]  masklane;
        logic [1:0]  trnmode;
        logic        orundetect;
    } ctrl_t;

    tap_state_t  state;
    tap_state_t  state_nxt;
    logic [34:0] sfter;
    logic [34:0] cap_data;
    ir_t         ir;
    ctrl_t       ctrl;
    ap_sel_t     apsel;
    logic [3:0]  apbanksel;
    word_t       dp_res;
    logic        dp_sel;
    logic        ack_wait_q;
    word_t       cmp_data;
    logic        cmp_en;
    logic [4:0]  buf_cnt;
    logic        tap_rst;
    logic        upd_dr;
    logic        dp_upd;
    logic        buf_ir;
    word_t       datain;
    logic [1:0]  a;
    logic        rnw;
    word_t       csr_word;
    word_t       sel_word;
    logic        lane_miss;
    logic        stickycmp;

    assign tap_rst = state == tap_reset;
    assign upd_dr  = state == tap_upd_dr;
    assign buf_ir  = ir == ir_apdbuf || ir == ir_aprbuf;

    assign datain = sfter[34:3];
    assign a      = sfter[2:1];
    assign rnw    = sfter[0];
    assign tdo    = sfter[0];

    assign dp_upd  = ir == ir_dpacc && upd_dr && !ack_wait_q;
    assign ap_upd  = ir == ir_apacc && upd_dr && !ack_wait_q;
    assign ap_req  = '{sel: apsel, addr: {apbanksel, a}, wdata: datain, rnw: rnw};
    assign dbgrstn = !(ctrl.cdbgrstreq && !ctrl.cdbgrstack) && !tap_rst;

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            state <= tap_reset;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            tap_reset:  state_nxt = tms ? tap_reset  : tap_run;
            tap_run:    state_nxt = tms ? tap_sel_dr : tap_run;
            tap_sel_dr: state_nxt = tms ? tap_sel_ir : tap_cap_dr;
            tap_cap_dr: state_nxt = tms ? tap_ex1_dr : tap_sft_dr;
            tap_sft_dr: state_nxt = tms ? tap_ex1_dr : tap_sft_dr;
            tap_ex1_dr: state_nxt = tms ? tap_upd_dr : tap_pau_dr;
            tap_pau_dr: state_nxt = tms ? tap_ex2_dr : tap_pau_dr;
            tap_ex2_dr: state_nxt = tms ? tap_upd_dr : tap_sft_dr;
            tap_upd_dr: state_nxt = tms ? tap_sel_dr : tap_run;
            tap_sel_ir: state_nxt = tms ? tap_reset  : tap_cap_ir;
            tap_cap_ir: state_nxt = tms ? tap_ex1_ir : tap_sft_ir;
            tap_sft_ir: state_nxt = tms ? tap_ex1_ir : tap_sft_ir;
            tap_ex1_ir: state_nxt = tms ? tap_upd_ir : tap_pau_ir;
            tap_pau_ir: state_nxt = tms ? tap_ex2_ir : tap_pau_ir;
            tap_ex2_ir: state_nxt = tms ? tap_upd_ir : tap_sft_ir;
            default:    state_nxt = tms ? tap_sel_dr : tap_run;
        endcase
    end

    // Pushed compare against the last posted DRW read.
    always_comb begin
        lane_miss = 1'b0;
        for (int i = 0; i < 4; i++) begin
            lane_miss |= ctrl.masklane[i] && (cmp_data[8*i +: 8] != ap_rsp.rdata[8*i +: 8]);
        end
    end

    assign stickycmp = (lane_miss ^ (ctrl.trnmode == 2'd2)) && ctrl.trnmode != 2'd0 && cmp_en;

    assign csr_word = {ctrl.csyspwrupack, ctrl.csyspwrupreq, ctrl.cdbgpwrupack,
                       ctrl.cdbgpwrupreq, ctrl.cdbgrstack, ctrl.cdbgrstreq, 2'b0,
                       ctrl.trncnt, ctrl.masklane, 2'b0, ap_rsp.slverr, stickycmp,
                       ctrl.trnmode, 1'b0, ctrl.orundetect};
    assign sel_word = {apsel, 16'h0, apbanksel, 4'h0};

    always_comb begin
        case (ir)
            ir_abort:           cap_data = {3'b0, unpredictable_word};
            ir_dpacc, ir_apacc: cap_data = {dp_sel ? dp_res : ap_rsp.rdata,
                                            ack_wait_q ? ack_wait : ack_ok_fault};
            ir_apdbuf:          cap_data = {3'b0, ap_buf.rdata};
            ir_aprbuf:          cap_data = {3'b0, ap_buf.rresp};
            ir_idcode:          cap_data = {3'b0, dap_ver, dap_partnum, dap_manid, 1'b1};
            default:            cap_data = '0;   // BYPASS.
        endcase
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            sfter <= '0;
        end else if (tap_rst) begin
            sfter <= '0;
        end else begin
            case (state)
                tap_cap_ir: sfter[3:0] <= 4'b0001;
                tap_sft_ir: sfter[3:0] <= {tdi, sfter[3:1]};
                tap_cap_dr: sfter      <= cap_data;
                tap_sft_dr: begin
                    case (ir)
                        ir_abort, ir_dpacc, ir_apacc: sfter <= {tdi, sfter[34:1]};
                        ir_apdbuf: sfter[31:0] <= ap_buf_dpop ? ap_buf.rdata
                                                              : {1'b0, sfter[31:1]};
                        ir_aprbuf: sfter[31:0] <= ap_buf_rpop ? ap_buf.rresp
                                                              : {1'b0, sfter[31:1]};
                        ir_idcode: sfter[31:0] <= {tdi, sfter[31:1]};
                        default:   sfter[0]    <= tdi;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            ir <= ir_idcode;
        end else if (tap_rst) begin
            ir <= ir_idcode;
        end else if (state == tap_upd_ir) begin
            ir <= sfter[3:0];
        end
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            ack_wait_q <= 1'b0;
            dp_sel     <= 1'b0;
            buf_cnt    <= '0;
        end else if (tap_rst) begin
            ack_wait_q <= 1'b0;
            dp_sel     <= 1'b0;
            buf_cnt    <= '0;
        end else begin
            if (state == tap_sel_dr && !tms) begin
                ack_wait_q <= ap_busy && (ir == ir_dpacc || ir == ir_apacc);
            end
            if (state == tap_cap_dr && ir == ir_dpacc) begin
                dp_sel <= 1'b1;   // Next capture returns the DP result.
            end else if (state == tap_cap_dr && ir == ir_apacc) begin
                dp_sel <= 1'b0;
            end
            if (buf_ir && state == tap_cap_dr) begin
                buf_cnt <= 5'd31;
            end else if (buf_ir && state == tap_sft_dr) begin
                buf_cnt <= buf_cnt - 5'd1;
            end
        end
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            ctrl      <= '0;
            apsel     <= '0;
            apbanksel <= '0;
            dp_res    <= '0;
            cmp_data  <= '0;
            cmp_en    <= 1'b0;
        end else if (tap_rst) begin
            ctrl      <= '0;
            apsel     <= '0;
            apbanksel <= '0;
            dp_res    <= '0;
            cmp_data  <= '0;
            cmp_en    <= 1'b0;
        end else begin
            ctrl.csyspwrupack <= ctrl.csyspwrupreq;
            ctrl.cdbgpwrupack <= ctrl.cdbgpwrupreq;
            ctrl.cdbgrstack   <= ctrl.cdbgrstreq;
            if (dp_upd && rnw) begin
                case (a)
                    2'd1:    dp_res <= csr_word;
                    2'd2:    dp_res <= sel_word;
                    2'd3:    dp_res <= '0;
                    default: dp_res <= unpredictable_word;
                endcase
            end else if (dp_upd) begin
                dp_res <= unpredictable_word;
                if (a == 2'd1) begin
                    ctrl.csyspwrupack <= 1'b0;
                    ctrl.cdbgpwrupack <= 1'b0;
                    ctrl.cdbgrstack   <= 1'b0;   // Opens the one-cycle dbgrstn pulse.
                    ctrl.csyspwrupreq <= datain[30];
                    ctrl.cdbgpwrupreq <= datain[28];
                    ctrl.cdbgrstreq   <= datain[26];
                    ctrl.trncnt       <= datain[23:12];
                    ctrl.masklane     <= datain[11:8];
                    ctrl.orundetect   <= datain[0];
                    if (datain[3:2] != 2'b11) begin
                        ctrl.trnmode <= datain[3:2];
                    end
                end
                if (a == 2'd2) begin
                    apsel     <= datain[31:24];
                    apbanksel <= datain[7:4];
                end
            end
            if (ap_upd) begin
                cmp_data <= datain;
                cmp_en   <= ap_req.rnw && ap_req.addr == ap_drw;
            end else if (dp_upd) begin
                cmp_en <= 1'b0;
            end
        end
    end

    assign ap_buf_dpop  = ir == ir_apdbuf &&
                          (state == tap_cap_dr || (state == tap_sft_dr && buf_cnt == '0));
    assign ap_buf_rpop  = ir == ir_aprbuf &&
                          (state == tap_cap_dr || (state == tap_sft_dr && buf_cnt == '0));
    assign ap_buf_rrstn = !(buf_ir && state == tap_sft_dr && tms);

endmodule

`default_nettype wire

// File: hdl/mem_ap.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ap import dap_pkg::*; (
    input  wire          tck,
    input  wire          trstn,
    input  wire          dbgrstn,
    input  wire          ap_upd,
    input  wire ap_req_t ap_req,
    output logic         ap_busy,
    output ap_rsp_t      ap_rsp,
    output logic         buf_push,
    output buf_out_t     buf_in,
    output mem_req_t     mem_req,
    output logic         mem_valid,
    input  wire ap_rsp_t mem_rsp
);

    ap_state_t state;
    ap_req_t   req_q;
    logic      lat_q;
    logic      csw_inc;
    word_t     tar;
    logic      accept;
    logic      sel_err;
    logic      is_drw;
    logic      tar_oor;
    logic      q_sel_err;
    logic      q_drw;
    word_t     reg_rdata;

    assign accept    = ap_upd && state == ap_idle;
    assign sel_err   = ap_req.sel != '0;   // Only AP 0 exists.
    assign is_drw    = ap_req.addr == ap_drw;
    assign tar_oor   = ap_req.wdata >= word_t'(mem_words * 4);
    assign q_sel_err = req_q.sel != '0;
    assign q_drw     = req_q.addr == ap_drw;

    assign reg_rdata = ap_req.addr == ap_csw ? {27'b0, csw_inc, 4'b0} :
                       ap_req.addr == ap_tar ? tar : '0;

    assign ap_busy   = state != ap_idle;
    assign mem_valid = state == ap_access && !lat_q && !q_sel_err;
    assign mem_req   = '{addr: tar, wdata: req_q.wdata, we: !req_q.rnw};
    assign buf_push  = state == ap_done && req_q.rnw;
    assign buf_in    = '{rdata: ap_rsp.rdata, rresp: {31'b0, ap_rsp.slverr}};

    always_ff @(posedge tck) begin
        if (accept) begin
            req_q <= ap_req;
        end
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            state  <= ap_idle;
            lat_q  <= 1'b0;
            ap_rsp <= '0;
        end else begin
            case (state)
                ap_idle: begin
                    lat_q <= 1'b0;
                    if (accept && is_drw) begin
                        state <= ap_access;
                    end else if (accept) begin
                        state         <= ap_done;   // CSW and TAR finish at once.
                        ap_rsp.slverr <= sel_err ||
                                         (ap_req.addr == ap_tar && !ap_req.rnw && tar_oor);
                        if (ap_req.rnw) begin
                            ap_rsp.rdata <= sel_err ? '0 : reg_rdata;
                        end
                    end
                end
                ap_access: begin
                    lat_q <= 1'b1;
                    if (lat_q) begin
                        state         <= ap_done;
                        ap_rsp.slverr <= q_sel_err || mem_rsp.slverr;
                        if (req_q.rnw) begin
                            ap_rsp.rdata <= q_sel_err ? '0 : mem_rsp.rdata;
                        end
                    end
                end
                default: state <= ap_idle;
            endcase
        end
    end

    always_ff @(posedge tck or negedge trstn) begin
        if (!trstn) begin
            csw_inc <= 1'b0;
            tar     <= '0;
        end else if (!dbgrstn) begin
            csw_inc <= 1'b0;
            tar     <= '0;
        end else if (accept && !ap_req.rnw && !sel_err) begin
            if (ap_req.addr == ap_csw) begin
                csw_inc <= ap_req.wdata[4];
            end
            if (ap_req.addr == ap_tar) begin
                tar <= ap_req.wdata;
            end
        end else if (state == ap_done && q_drw && csw_inc) begin
            tar <= tar + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: project.f
hdl/dap_pkg.sv
hdl/debug_mem.sv
hdl/ap_read_buf.sv
hdl/mem_ap.sv
hdl/jtag_dp.sv
hdl/dap_top.sv
+incdir+testbench
testbench/dap_tb.sv

// File: testbench/dap_golden.txt
# I ir | D tdi expected mask (35-bit hex) | F same on the fast path
# B word_count words... | R tms reset of the TAP | T test_name
D 000000000 010ba1477 7ffffffff
I f
D 123456789 2468acf12 7ffffffff
T idcode_bypass
I a
D 2855e282a 000000002 7ffffffff
D 000000003 6f56ef56a 7ffffffff
D 2855e286a 7855e282a 7ffffffff
D 090000184 6f56ef56a 7ffffffff
D 000000003 6f56ef56a 7ffffffff
D 000000005 7855e282a 7ffffffff
D 000000004 090000182 7ffffffff
T dp_regs
I b
D 000000080 6f56ef56a 7ffffffff
D 000000082 000000002 7ffffffff
D 08888888e 000000002 7ffffffff
D 111111116 000000002 7ffffffff
D 000000082 000000002 7ffffffff
D 000000007 000000002 7ffffffff
F 19999999e 000000001 7ffffffff
D 000000007 08888888a 7ffffffff
D 000000003 111111112 7ffffffff
D 000000001 0000000c2 7ffffffff
T apacc
I a
D 000007822 000000082 7ffffffff
I b
D 000000082 6f56ef56a 7ffffffff
D 091a2b3c7 000000082 7ffffffff
I a
D 000000003 08888888a 7ffffffff
D 000007842 0000078a2 7ffffffff
I b
D 111111117 6f56ef56a 7ffffffff
I a
D 000000003 111111112 7ffffffff
I b
D 000000802 0000078c2 7ffffffff
I a
D 000000003 111111112 7ffffffff
D 000000003 000007942 7ffffffff
T compare_error
I b
D 000000007 000007942 7ffffffff
I c
B 7 11111111 22222222 00000018 00000010 11111111 22222222 00000000
B 1 00000000
I b
D 000000007 000000002 7ffffffff
D 000000082 000000002 7ffffffff
D 000000007 000000002 7ffffffff
I d
B 2 00000001 00000000
T read_buffer
I a
D 020000002 08888888a 7ffffffff
I b
D 000000003 6f56ef56a 7ffffffff
D 000000001 000000002 7ffffffff
D 000000003 000000002 7ffffffff
R
D 000000000 010ba1477 7ffffffff
T tap_reset

// File: testbench/jtag_tasks.svh
`ifndef jtag_tasks_svh
`define jtag_tasks_svh

// One TCK cycle: sample tdo, then drive tms and tdi for the next rising edge.
task automatic clock_bit(input logic tms_v, input logic tdi_v, output logic tdo_v);
    @(negedge tck);
    tdo_v = tdo;
    tms   = tms_v;
    tdi   = tdi_v;
endtask

// Moves the TAP into Select-DR-Scan.
task automatic enter_select_dr(input bit fast);
    logic unused;
    if (fast && in_update) begin
        clock_bit(1'b1, 1'b0, unused);   // Update-DR straight to Select-DR.
    end else begin
        repeat (3) begin
            clock_bit(1'b0, 1'b0, unused);   // Idle long enough for the AP to finish.
        end
        clock_bit(1'b1, 1'b0, unused);
    end
    in_update = 1'b0;
endtask

// Full DR scan, leaves the TAP in Update-DR.
task automatic scan_dr(input int nbits, input logic [255:0] din, input bit fast,
                       output logic [255:0] dout);
    logic unused;
    logic bit_out;
    dout = '0;
    enter_select_dr(fast);
    clock_bit(1'b0, 1'b0, unused);   // To Capture-DR.
    clock_bit(1'b0, 1'b0, unused);   // To Shift-DR.
    for (int i = 0; i < nbits; i++) begin
        clock_bit(i == nbits - 1, din[i], bit_out);
        dout[i] = bit_out;
    end
    clock_bit(1'b1, 1'b0, unused);   // To Update-DR.
    in_update = 1'b1;
endtask

// IR scan, returns the four captured bits.
task automatic scan_ir(input ir_t code, output logic [3:0] captured);
    logic unused;
    logic bit_out;
    captured = '0;
    enter_select_dr(1'b0);
    clock_bit(1'b1, 1'b0, unused);   // To Select-IR.
    clock_bit(1'b0, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    for (int i = 0; i < 4; i++) begin
        clock_bit(i == 3, code[i], bit_out);
        captured[i] = bit_out;
    end
    clock_bit(1'b1, 1'b0, unused);   // To Update-IR.
    in_update = 1'b1;
endtask

// Five cycles with tms high reach Test-Logic-Reset from any state.
task automatic reset_tap_tms();
    logic unused;
    repeat (5) begin
        clock_bit(1'b1, 1'b0, unused);
    end
    in_update = 1'b0;
endtask

`endif

// File: testbench/dap_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dap_tb import dap_pkg::*; ();

    logic tck;
    logic trstn;
    logic tms;
    logic tdi;
    logic tdo;
    logic dbgrstn;

    bit   in_update;
    int   errors;
    int   test_errors;
    int   tests_run;
    int   tests_failed;
    int   wd_cycles;
    int   rst_pulses_exp;
    int   rst_pulses_seen;
    logic [2:0] rst_hist;

    dap_top dap_top_i (
        .tck     (tck),
        .trstn   (trstn),
        .tms     (tms),
        .tdi     (tdi),
        .tdo     (tdo),
        .dbgrstn (dbgrstn)
    );

    `include "jtag_tasks.svh"

    task automatic check_value(input string name, input logic [34:0] actual,
                               input logic [34:0] expected, input logic [34:0] mask);
        if ((actual & mask) !== (expected & mask)) begin
            $display("Error at %0t ns: %0s = %h, expected %h", $time, name,
                     actual & mask, expected & mask);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        tck = 1'b0;
        forever #2 tck = ~tck;
    end

    // Counts single-cycle low pulses on dbgrstn.
    initial begin
        rst_hist        = '0;
        rst_pulses_seen = 0;
        forever begin
            @(negedge tck);
            rst_hist = {rst_hist[1:0], dbgrstn === 1'b1};
            if (rst_hist == 3'b101) begin
                rst_pulses_seen++;
            end
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge tck);
        $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int                fd;
        int                code;
        int                nlines;
        int                count;
        logic [8*16-1:0]   kind;
        logic [8*32-1:0]   name;
        logic [8*256-1:0]  line;
        logic [34:0]       din;
        logic [34:0]       dexp;
        logic [34:0]       dmask;
        ir_t               ir_val;
        logic [3:0]        ir_cap;
        logic [255:0]      sin;
        logic [255:0]      sout;
        word_t             w;

        tms            = 1'b0;
        tdi            = 1'b0;
        trstn          = 1'b0;
        in_update      = 1'b0;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        wd_cycles      = 0;
        nlines         = 0;
        rst_pulses_exp = 0;
        ir_val         = ir_idcode;

        fd = $fopen("testbench/dap_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file testbench/dap_golden.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                nlines++;
            end
            $fclose(fd);
            wd_cycles = nlines * 200 + 50;   // Reset and margin included.
            fd = $fopen("testbench/dap_golden.txt", "r");

            repeat (8) @(negedge tck);
            trstn = 1'b1;

            while ($fscanf(fd, " %s", kind) == 1) begin
                case (kind)
                    "#": code = $fgets(line, fd);
                    "I": begin
                        code = $fscanf(fd, " %h", ir_val);
                        scan_ir(ir_val, ir_cap);
                        check_value("ir_capture", {31'b0, ir_cap}, 35'h1, 35'hf);
                    end
                    "D", "F": begin
                        code = $fscanf(fd, " %h %h %h", din, dexp, dmask);
                        sin = '0;
                        sin[34:0] = din;
                        scan_dr(35, sin, kind == "F", sout);
                        check_value("tdo_dr", sout[34:0], dexp, dmask);
                        if (ir_val == ir_dpacc && din[2:0] == 3'b010 && din[29]) begin
                            rst_pulses_exp++;   // CTRL/STAT write with cdbgrstreq.
                        end
                    end
                    "B": begin
                        code = $fscanf(fd, " %d", count);
                        if (count < 1 || count > 8) begin
                            $display("Buffer scan of %0d words is out of range", count);
                            errors++;
                            test_errors++;
                        end else begin
                            scan_dr(count * 32, '0, 1'b0, sout);
                            for (int i = 0; i < count; i++) begin
                                code = $fscanf(fd, " %h", w);
                                check_value($sformatf("buffer_word_%0d", i),
                                            {3'b0, sout[32*i +: 32]}, {3'b0, w},
                                            35'hffffffff);
                            end
                        end
                    end
                    "R": begin
                        reset_tap_tms();
                        ir_val = ir_idcode;
                        check_value("dbgrstn", {34'b0, dbgrstn}, 35'h0, 35'h1);
                    end
                    "T": begin
                        code = $fscanf(fd, " %s", name);
                        check_value("dbgrstn_pulses", rst_pulses_seen, rst_pulses_exp,
                                    35'h7ffffffff);
                        tests_run++;
                        if (test_errors == 0) begin
                            $display("Test %0s: pass", name);
                        end else begin
                            $display("Test %0s: fail", name);
                            tests_failed++;
                        end
                        test_errors = 0;
                    end
                    default: begin
                        $display("Unknown line kind %0s in the golden file", kind);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
